/* flist.f */
+incdir+include
logic/hl_cmd_pkg.sv
logic/hl_link_pkg.sv
logic/ds_cmd_parser.sv
logic/radio_control.sv
logic/us_resp_tx.sv
logic/hl_cmd_top.sv
verif/tb_hl_cmd_top.sv

/* include/hl_consts.svh */
////////////////////////////////////////
// Command path constants
// Frame layout, command addresses and watchdog default
////////////////////////////////////////

`ifndef HL_CONSTS_SVH
`define HL_CONSTS_SVH

// Sync byte, sent three times ahead of C0
`define HL_SYNC_BYTE 8'h7F

// Downstream frame is 3 sync + C0 + 4 data bytes
`define HL_FRAME_BYTES 8

// Upstream echo is C0 + 4 data bytes
`define HL_RESP_BYTES 5

// Command addresses
`define HL_ADDR_CONFIG 6'h00
`define HL_ADDR_CW 6'h0F

// Cycles without a command before run drops
`define HL_WATCHDOG_CYCLES 2000

`endif

/* logic/ds_cmd_parser.sv */
////////////////////////////////////////
// Downstream command parser
// Hunts 7F 7F 7F sync and decodes C0..C4
////////////////////////////////////////

`timescale 1ns/100ps

`include "hl_consts.svh"

module ds_cmd_parser (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,
  input  logic                  eth_valid_i,
  input  hl_link_pkg::byte_t    eth_data_i,
  output logic                  cmd_valid_o,
  output hl_cmd_pkg::cmd_addr_t cmd_addr_o,
  output hl_cmd_pkg::cmd_data_t cmd_data_o,
  output logic                  cmd_ptt_o,
  output logic                  resp_rqst_o
);

  // Data bytes follow the three sync bytes and C0
  localparam hl_link_pkg::beat_cnt_t LAST_BEAT =
    hl_link_pkg::beat_cnt_t'(`HL_FRAME_BYTES - 5);

  hl_link_pkg::parse_state_t state_q;
  hl_link_pkg::beat_cnt_t    beat_q;
  hl_link_pkg::byte_t        c0_q;
  logic [23:0]               data_sr;
  logic                      is_sync;
  logic                      last_byte;

  assign is_sync   = (eth_data_i == `HL_SYNC_BYTE);
  assign last_byte = eth_valid_i && (state_q == hl_link_pkg::DATA) &&
                     (beat_q == LAST_BEAT);

  ////////////////////////////////////////
  // Frame state machine

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state_q <= hl_link_pkg::SYNC0;
      beat_q  <= '0;
    end else if (eth_valid_i) begin
      case (state_q)
        hl_link_pkg::SYNC0: state_q <= is_sync ? hl_link_pkg::SYNC1 : hl_link_pkg::SYNC0;
        hl_link_pkg::SYNC1: state_q <= is_sync ? hl_link_pkg::SYNC2 : hl_link_pkg::SYNC0;
        hl_link_pkg::SYNC2: state_q <= is_sync ? hl_link_pkg::C0 : hl_link_pkg::SYNC0;
        hl_link_pkg::C0: begin
          state_q <= hl_link_pkg::DATA;
          beat_q  <= '0;
        end
        hl_link_pkg::DATA: begin
          if (beat_q == LAST_BEAT) begin
            state_q <= hl_link_pkg::SYNC0;
          end else begin
            beat_q <= beat_q + 3'd1;
          end
        end
        default: state_q <= hl_link_pkg::SYNC0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Field capture

  always_ff @(posedge clk_ctrl) begin
    if (eth_valid_i && (state_q == hl_link_pkg::C0)) begin
      c0_q <= eth_data_i;
    end
    if (eth_valid_i && (state_q == hl_link_pkg::DATA)) begin
      data_sr <= {data_sr[15:0], eth_data_i};
    end
    // C4 completes the word
    if (last_byte) begin
      cmd_addr_o <= c0_q[6:1];
      cmd_ptt_o  <= c0_q[0];
      cmd_data_o <= {data_sr, eth_data_i};
    end
  end

  // Strobes, one cycle after C4
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      cmd_valid_o <= 1'b0;
      resp_rqst_o <= 1'b0;
    end else begin
      cmd_valid_o <= last_byte;
      resp_rqst_o <= last_byte && c0_q[7];
    end
  end

  // Frames are 8 bytes long, so strobes never touch
  a_cmd_valid_pulse : assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    cmd_valid_o |=> !cmd_valid_o
  );

endmodule

/* logic/hl_cmd_pkg.sv */
////////////////////////////////////////
// Command content types
// Fields of a decoded command and the watchdog count
////////////////////////////////////////

package hl_cmd_pkg;

  // Address field of C0, bits 6 to 1
  typedef logic [5:0] cmd_addr_t;

  // C1 to C4, most significant byte first
  typedef logic [31:0] cmd_data_t;

  // Cycles since the last command
  typedef logic [15:0] wdog_cnt_t;

endpackage

/* logic/hl_cmd_top.sv */
////////////////////////////////////////
// Command path top level
// Parser, control registers and echo serializer
////////////////////////////////////////

`timescale 1ns/100ps

`include "hl_consts.svh"

module hl_cmd_top #(
  parameter int unsigned WATCHDOG_LIMIT = `HL_WATCHDOG_CYCLES
) (
  input  logic               clk_ctrl,
  input  logic               rst_n_i,
  input  logic               eth_valid_i,
  input  hl_link_pkg::byte_t eth_data_i,
  input  logic               resp_ready_i,
  output logic               resp_valid_o,
  output hl_link_pkg::byte_t resp_data_o,
  output logic               resp_last_o,
  output logic               resp_overrun_o,
  output logic               run_o,
  output logic               tx_on_o,
  output logic               cw_keydown_o
);

  // Decoded command, shared by both consumers
  logic                  cmd_valid;
  hl_cmd_pkg::cmd_addr_t cmd_addr;
  hl_cmd_pkg::cmd_data_t cmd_data;
  logic                  cmd_ptt;
  logic                  resp_rqst;

  ds_cmd_parser ds_cmd_parser_i (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .eth_valid_i (eth_valid_i),
    .eth_data_i  (eth_data_i),
    .cmd_valid_o (cmd_valid),
    .cmd_addr_o  (cmd_addr),
    .cmd_data_o  (cmd_data),
    .cmd_ptt_o   (cmd_ptt),
    .resp_rqst_o (resp_rqst)
  );

  radio_control #(.WATCHDOG_LIMIT(WATCHDOG_LIMIT)) radio_control_i (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid),
    .cmd_addr_i   (cmd_addr),
    .cmd_data_i   (cmd_data),
    .cmd_ptt_i    (cmd_ptt),
    .run_o        (run_o),
    .tx_on_o      (tx_on_o),
    .cw_keydown_o (cw_keydown_o)
  );

  us_resp_tx us_resp_tx_i (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .resp_rqst_i    (resp_rqst),
    .cmd_addr_i     (cmd_addr),
    .cmd_data_i     (cmd_data),
    .cmd_ptt_i      (cmd_ptt),
    .resp_ready_i   (resp_ready_i),
    .resp_valid_o   (resp_valid_o),
    .resp_data_o    (resp_data_o),
    .resp_last_o    (resp_last_o),
    .resp_overrun_o (resp_overrun_o)
  );

endmodule

/* logic/hl_link_pkg.sv */
////////////////////////////////////////
// Byte link types
// Stream byte and framing state machines
////////////////////////////////////////

package hl_link_pkg;

  typedef logic [7:0] byte_t;

  // Downstream frame hunt
  typedef enum logic [2:0] {SYNC0, SYNC1, SYNC2, C0, DATA} parse_state_t;

  // Upstream echo
  typedef enum logic {IDLE, SEND} resp_state_t;

  // Byte position inside a frame or response
  typedef logic [2:0] beat_cnt_t;

endpackage

/* logic/radio_control.sv */
////////////////////////////////////////
// Radio control registers
// Run, PTT and CW key with command watchdog
////////////////////////////////////////

`timescale 1ns/100ps

`include "hl_consts.svh"

module radio_control #(
  parameter int unsigned WATCHDOG_LIMIT = `HL_WATCHDOG_CYCLES
) (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,
  input  logic                  cmd_valid_i,
  input  hl_cmd_pkg::cmd_addr_t cmd_addr_i,
  input  hl_cmd_pkg::cmd_data_t cmd_data_i,
  input  logic                  cmd_ptt_i,
  output logic                  run_o,
  output logic                  tx_on_o,
  output logic                  cw_keydown_o
);

  localparam hl_cmd_pkg::wdog_cnt_t WDOG_LIMIT =
    hl_cmd_pkg::wdog_cnt_t'(WATCHDOG_LIMIT);

  hl_cmd_pkg::wdog_cnt_t wdog_cnt_q;
  logic                  wdog_fire;

  // A command arriving on the limit cycle keeps the radio alive
  assign wdog_fire = run_o && !cmd_valid_i && (wdog_cnt_q == WDOG_LIMIT);

  ////////////////////////////////////////
  // Watchdog counter

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      wdog_cnt_q <= '0;
    end else if (cmd_valid_i || !run_o || wdog_fire) begin
      wdog_cnt_q <= '0;
    end else begin
      wdog_cnt_q <= wdog_cnt_q + 16'd1;
    end
  end

  ////////////////////////////////////////
  // Control state

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      run_o        <= 1'b0;
      tx_on_o      <= 1'b0;
      cw_keydown_o <= 1'b0;
    end else if (wdog_fire) begin
      run_o        <= 1'b0;
      tx_on_o      <= 1'b0;
      cw_keydown_o <= 1'b0;
    end else if (cmd_valid_i) begin
      // PTT rides along in every frame
      tx_on_o <= cmd_ptt_i;
      if (cmd_addr_i == `HL_ADDR_CONFIG) begin
        run_o <= cmd_data_i[0];
      end
      if (cmd_addr_i == `HL_ADDR_CW) begin
        cw_keydown_o <= cmd_data_i[0];
      end
    end
  end

  // Transmit must never outlive a lost host
  a_wdog_kills_tx : assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    wdog_fire |=> !tx_on_o && !run_o && !cw_keydown_o
  );

endmodule

/* logic/us_resp_tx.sv */
////////////////////////////////////////
// Upstream response serializer
// Echoes a command as five bytes, valid/ready
////////////////////////////////////////

`timescale 1ns/100ps

`include "hl_consts.svh"

module us_resp_tx (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,
  input  logic                  resp_rqst_i,
  input  hl_cmd_pkg::cmd_addr_t cmd_addr_i,
  input  hl_cmd_pkg::cmd_data_t cmd_data_i,
  input  logic                  cmd_ptt_i,
  input  logic                  resp_ready_i,
  output logic                  resp_valid_o,
  output hl_link_pkg::byte_t    resp_data_o,
  output logic                  resp_last_o,
  output logic                  resp_overrun_o
);

  localparam int unsigned RESP_W = `HL_RESP_BYTES * 8;
  localparam hl_link_pkg::beat_cnt_t LAST_BEAT =
    hl_link_pkg::beat_cnt_t'(`HL_RESP_BYTES - 1);

  hl_link_pkg::resp_state_t state_q;
  hl_link_pkg::beat_cnt_t   beat_q;
  logic [RESP_W-1:0]        resp_sr;
  logic                     xfer;

  assign resp_valid_o = (state_q == hl_link_pkg::SEND);
  assign resp_data_o  = resp_sr[RESP_W-1 -: 8];
  assign resp_last_o  = resp_valid_o && (beat_q == LAST_BEAT);
  assign xfer         = resp_valid_o && resp_ready_i;

  ////////////////////////////////////////
  // Byte sequencing

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state_q        <= hl_link_pkg::IDLE;
      beat_q         <= '0;
      resp_overrun_o <= 1'b0;
    end else begin
      if ((state_q == hl_link_pkg::IDLE) && resp_rqst_i) begin
        state_q <= hl_link_pkg::SEND;
        beat_q  <= '0;
      end else if (xfer) begin
        if (resp_last_o) begin
          state_q <= hl_link_pkg::IDLE;
          beat_q  <= '0;
        end else begin
          beat_q <= beat_q + 3'd1;
        end
      end
      // Busy, the request is lost
      if ((state_q == hl_link_pkg::SEND) && resp_rqst_i) begin
        resp_overrun_o <= 1'b1;
      end
    end
  end

  // Echo word, byte 0 rebuilds C0 with the response bit set
  always_ff @(posedge clk_ctrl) begin
    if ((state_q == hl_link_pkg::IDLE) && resp_rqst_i) begin
      resp_sr <= {1'b1, cmd_addr_i, cmd_ptt_i, cmd_data_i};
    end else if (xfer) begin
      resp_sr <= {resp_sr[RESP_W-9:0], 8'h00};
    end
  end

  a_hold_on_stall : assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    (resp_valid_o && !resp_ready_i) |=>
      resp_valid_o && $stable(resp_data_o) && $stable(resp_last_o)
  );

endmodule

/* verif/tb_hl_cmd_top.sv */
////////////////////////////////////////
// Command path testbench
// Frames, echoes and watchdog against a model
////////////////////////////////////////

`timescale 1ns/100ps

`include "hl_consts.svh"

module tb_hl_cmd_top;

  // About ten times the watchdog limit plus traffic
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk_ctrl = 1'b0;
  logic rst_n_i, eth_valid_i, resp_ready_i;
  hl_link_pkg::byte_t eth_data_i, resp_data_o;
  logic resp_valid_o, resp_last_o, resp_overrun_o, run_o, tx_on_o, cw_keydown_o;

  // Frame on the wire, as the model sees it
  logic drv_c4, drv_rqst, drv_ptt;
  hl_cmd_pkg::cmd_addr_t drv_addr, m_addr;
  hl_cmd_pkg::cmd_data_t drv_data, m_data;

  // Model state, control is {run, tx_on, cw_keydown}, response is {valid, last, data}
  logic m_cv, m_rqst, m_ptt, m_overrun, m_fire;
  logic [2:0] m_ctl, dut_ctl;
  logic [9:0] m_resp, dut_resp;
  int m_idle;
  hl_link_pkg::byte_t exp_q[$];

  logic [31:0] rng, ready_rng;
  int ready_mode;
  int cycle_cnt = 0;
  string test_name;

  always #10 clk_ctrl = ~clk_ctrl;

  hl_cmd_top hl_cmd_top_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic roll(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  task automatic fail_out(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic mismatch(input string what, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    fail_out($sformatf("ERR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v));
  endtask

  task automatic send_byte(input hl_link_pkg::byte_t b, input logic last);
    @(negedge clk_ctrl);
    eth_valid_i = 1'b1;
    eth_data_i  = b;
    drv_c4      = last;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_ctrl);
      eth_valid_i = 1'b0;
      drv_c4      = 1'b0;
    end
  endtask

  task automatic send_frame(input logic rqst, input hl_cmd_pkg::cmd_addr_t addr,
                            input logic ptt, input hl_cmd_pkg::cmd_data_t data);
    logic [63:0] f;
    logic [31:0] r;
    f = {{3{`HL_SYNC_BYTE}}, rqst, addr, ptt, data};
    {drv_rqst, drv_addr, drv_ptt, drv_data} = {rqst, addr, ptt, data};
    for (int i = 7; i >= 0; i--) begin
      send_byte(f[8*i +: 8], i == 0);
    end
    roll(r);
    idle(1 + r[1:0]);
  endtask

  // Never three sync bytes in a row, and never ending on one
  task automatic send_garbage(input int items);
    logic [31:0] r;
    for (int i = 0; i < items; i++) begin
      roll(r);
      repeat (r[1:0] % 3) send_byte(`HL_SYNC_BYTE, 1'b0);
      send_byte((r[15:8] == `HL_SYNC_BYTE) ? 8'hA5 : r[15:8], 1'b0);
      idle(r[4]);
    end
  endtask

  task automatic wait_resp_done();
    do @(negedge clk_ctrl); while (resp_valid_o || exp_q.size() != 0);
  endtask

  task automatic set_ready(input int mode);
    @(posedge clk_ctrl);
    ready_mode = mode;
  endtask

  // Sink ready: 0 always, 1 random, 2 held low
  always @(negedge clk_ctrl) begin
    if (ready_mode == 1) begin
      ready_rng = xorshift32(ready_rng);
      resp_ready_i = ready_rng[7];
    end else begin
      resp_ready_i = (ready_mode == 0);
    end
  end

  ////////////////////////////////////////
  // Reference model

  assign m_fire = m_ctl[2] && !m_cv && (m_idle == `HL_WATCHDOG_CYCLES);

  always @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      {m_cv, m_ctl, m_overrun, m_resp} <= '0;
      m_idle <= 0;
      exp_q.delete();
    end else begin
      m_cv <= eth_valid_i && drv_c4;
      if (eth_valid_i && drv_c4) begin
        {m_rqst, m_addr, m_ptt, m_data} <= {drv_rqst, drv_addr, drv_ptt, drv_data};
      end
      // Command lands on the edge after C4, watchdog wins
      if (m_fire) begin
        m_ctl <= 3'b000;
      end else if (m_cv) begin
        m_ctl <= {(m_addr == `HL_ADDR_CONFIG) ? m_data[0] : m_ctl[2], m_ptt,
                  (m_addr == `HL_ADDR_CW) ? m_data[0] : m_ctl[0]};
      end
      m_idle <= (m_cv || !m_ctl[2]) ? 0 : m_idle + 1;
      if (exp_q.size() != 0) begin
        if (m_cv && m_rqst) begin
          m_overrun <= 1'b1;
        end
        if (resp_ready_i) begin
          void'(exp_q.pop_front());
        end
      end else if (m_cv && m_rqst) begin
        exp_q = '{{1'b1, m_addr, m_ptt}, m_data[31:24], m_data[23:16],
                  m_data[15:8], m_data[7:0]};
      end
      m_resp <= (exp_q.size() == 0) ? 10'h000 : {1'b1, exp_q.size() == 1, exp_q[0]};
    end
  end

  assign dut_ctl  = {run_o, tx_on_o, cw_keydown_o};
  assign dut_resp = {resp_valid_o, resp_last_o, resp_valid_o ? resp_data_o : 8'h00};

  a_ctl : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) dut_ctl == m_ctl)
    else mismatch("run/tx_on/cw_keydown", $sampled(m_ctl), $sampled(dut_ctl));
  a_resp : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) dut_resp == m_resp)
    else mismatch("valid/last/data", $sampled(m_resp), $sampled(dut_resp));
  a_overrun : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_overrun_o == m_overrun)
    else mismatch("resp_overrun_o", $sampled(m_overrun), $sampled(resp_overrun_o));
  a_stall : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    (resp_valid_o && !resp_ready_i) |=> $stable(resp_data_o) && $stable(resp_last_o))
    else fail_out("Response byte changed while the sink was stalled");

  always @(posedge clk_ctrl) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_out("Timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    logic [31:0] r;
    {rst_n_i, eth_valid_i, resp_ready_i, drv_c4, drv_rqst, drv_ptt} = '0;
    eth_data_i = '0;
    drv_addr   = '0;
    drv_data   = '0;
    rng        = 32'h6ceb_05d9;
    ready_rng  = 32'h6ceb_05d9;
    ready_mode = 0;
    test_name  = "reset";
    repeat (10) @(negedge clk_ctrl);
    rst_n_i = 1'b1;

    test_name = "decode";
    roll(r);
    send_frame(1'b0, `HL_ADDR_CONFIG, 1'b0, r | 32'h1);
    send_frame(1'b0, `HL_ADDR_CW, 1'b1, 32'h1);
    send_frame(1'b0, 6'h2A, 1'b0, r);
    send_frame(1'b0, `HL_ADDR_CW, 1'b0, 32'h0);

    test_name = "resync";
    send_garbage(16);
    send_frame(1'b0, `HL_ADDR_CONFIG, 1'b1, 32'h1);
    send_garbage(16);

    test_name = "echo";
    roll(r);
    send_frame(1'b1, r[5:0], r[6], xorshift32(r));
    wait_resp_done();
    send_frame(1'b0, r[13:8], 1'b1, r);
    idle(8);

    test_name = "backpressure";
    set_ready(1);
    repeat (4) begin
      roll(r);
      send_frame(1'b1, r[5:0], r[6], xorshift32(r));
      wait_resp_done();
    end

    test_name = "overrun";
    set_ready(2);
    roll(r);
    send_frame(1'b1, 6'h11, 1'b1, r);
    do @(negedge clk_ctrl); while (!resp_valid_o);
    send_frame(1'b1, 6'h22, 1'b0, ~r);
    set_ready(0);
    wait_resp_done();

    test_name = "watchdog";
    send_frame(1'b0, `HL_ADDR_CONFIG, 1'b1, 32'h1);
    send_frame(1'b0, `HL_ADDR_CW, 1'b1, 32'h1);
    idle(`HL_WATCHDOG_CYCLES * 3 / 4);
    send_frame(1'b0, 6'h05, 1'b1, 32'h0);
    idle(`HL_WATCHDOG_CYCLES * 3 / 4);
    do @(negedge clk_ctrl); while (run_o);
    idle(10);

    $display("Test passed");
    $finish;
  end

endmodule
